// File: source/bitmanip_pkg.sv
package bitmanip_pkg;

    localparam int xlen       = 32;  // rv32 only
    localparam int n_checkers = 4;   // peers sharing the spec bus

    typedef logic [xlen-1:0] xlen_t;        // register and pc values
    typedef logic [31:0]     insn_t;        // raw instruction word
    typedef logic [4:0]      reg_addr_t;    // register index
    typedef logic [15:0]     fail_count_t;  // saturating mismatch count

    // r-type ops, funct7 + funct3 + opcode are fixed
    localparam insn_t max_mask   = 32'hfe00707f;
    localparam insn_t max_match  = 32'h0a006033;
    localparam insn_t maxu_mask  = 32'hfe00707f;
    localparam insn_t maxu_match = 32'h0a007033;
    localparam insn_t min_mask   = 32'hfe00707f;
    localparam insn_t min_match  = 32'h0a004033;
    localparam insn_t minu_mask  = 32'hfe00707f;
    localparam insn_t minu_match = 32'h0a005033;

    localparam insn_t andn_mask  = 32'hfe00707f;
    localparam insn_t andn_match = 32'h40007033;
    localparam insn_t orn_mask   = 32'hfe00707f;
    localparam insn_t orn_match  = 32'h40006033;
    localparam insn_t xnor_mask  = 32'hfe00707f;
    localparam insn_t xnor_match = 32'h40004033;

    // unary ops, rs2 field selects the operation
    localparam insn_t clz_mask   = 32'hfff0707f;
    localparam insn_t clz_match  = 32'h60001013;
    localparam insn_t ctz_mask   = 32'hfff0707f;
    localparam insn_t ctz_match  = 32'h60101013;
    localparam insn_t cpop_mask  = 32'hfff0707f;
    localparam insn_t cpop_match = 32'h60201013;

    localparam insn_t rol_mask   = 32'hfe00707f;
    localparam insn_t rol_match  = 32'h60001033;
    localparam insn_t ror_mask   = 32'hfe00707f;
    localparam insn_t ror_match  = 32'h60005033;
    localparam insn_t rori_mask  = 32'hfe00707f;  // shamt[5] must be zero on rv32
    localparam insn_t rori_match = 32'h60005013;

endpackage

// File: source/insn_minmax_checker.sv
module insn_minmax_checker #(
    parameter logic [3:0] minmax_en = 4'b1111  // max, maxu, min, minu
) (
    input  logic                 rvfi_valid,
    input  bitmanip_pkg::insn_t  rvfi_insn,
    input  bitmanip_pkg::xlen_t  rvfi_rs1_rdata,
    input  bitmanip_pkg::xlen_t  rvfi_rs2_rdata,
    output logic                 spec_valid,
    output bitmanip_pkg::xlen_t  spec_rd_wdata
);

    import bitmanip_pkg::*;

    logic  dec_max;
    logic  dec_maxu;
    logic  dec_min;
    logic  dec_minu;
    xlen_t rs1;
    xlen_t rs2;
    xlen_t result_max;
    xlen_t result_maxu;
    xlen_t result_min;
    xlen_t result_minu;

    assign dec_max  = rvfi_valid && ((rvfi_insn & max_mask) == max_match);
    assign dec_maxu = rvfi_valid && ((rvfi_insn & maxu_mask) == maxu_match);
    assign dec_min  = rvfi_valid && ((rvfi_insn & min_mask) == min_match);
    assign dec_minu = rvfi_valid && ((rvfi_insn & minu_mask) == minu_match);

    assign spec_valid = (dec_max && minmax_en[0]) ||
                        (dec_maxu && minmax_en[1]) ||
                        (dec_min && minmax_en[2]) ||
                        (dec_minu && minmax_en[3]);

    assign rs1 = rvfi_rs1_rdata;
    assign rs2 = rvfi_rs2_rdata;

    assign result_max  = ($signed(rs1) > $signed(rs2)) ? rs1 : rs2;
    assign result_min  = ($signed(rs1) < $signed(rs2)) ? rs1 : rs2;
    assign result_maxu = (rs1 > rs2) ? rs1 : rs2;  // plain vectors compare unsigned
    assign result_minu = (rs1 < rs2) ? rs1 : rs2;

    // decodes are exclusive, so an and-or mux is enough
    assign spec_rd_wdata = ({xlen{dec_max}} & result_max) |
                           ({xlen{dec_maxu}} & result_maxu) |
                           ({xlen{dec_min}} & result_min) |
                           ({xlen{dec_minu}} & result_minu);

endmodule

// File: source/insn_logic_neg_checker.sv
module insn_logic_neg_checker #(
    parameter logic [2:0] logic_en = 3'b111  // andn, orn, xnor
) (
    input  logic                 rvfi_valid,
    input  bitmanip_pkg::insn_t  rvfi_insn,
    input  bitmanip_pkg::xlen_t  rvfi_rs1_rdata,
    input  bitmanip_pkg::xlen_t  rvfi_rs2_rdata,
    output logic                 spec_valid,
    output bitmanip_pkg::xlen_t  spec_rd_wdata
);

    import bitmanip_pkg::*;

    logic  dec_andn;
    logic  dec_orn;
    logic  dec_xnor;
    xlen_t result_andn;
    xlen_t result_orn;
    xlen_t result_xnor;

    assign dec_andn = rvfi_valid && ((rvfi_insn & andn_mask) == andn_match);
    assign dec_orn  = rvfi_valid && ((rvfi_insn & orn_mask) == orn_match);
    assign dec_xnor = rvfi_valid && ((rvfi_insn & xnor_mask) == xnor_match);

    assign spec_valid = (dec_andn && logic_en[0]) ||
                        (dec_orn && logic_en[1]) ||
                        (dec_xnor && logic_en[2]);

    assign result_andn = rvfi_rs1_rdata & ~rvfi_rs2_rdata;
    assign result_orn  = rvfi_rs1_rdata | ~rvfi_rs2_rdata;
    assign result_xnor = ~(rvfi_rs1_rdata ^ rvfi_rs2_rdata);

    assign spec_rd_wdata = ({xlen{dec_andn}} & result_andn) |
                           ({xlen{dec_orn}} & result_orn) |
                           ({xlen{dec_xnor}} & result_xnor);

endmodule

// File: source/insn_count_checker.sv
module insn_count_checker #(
    parameter logic [2:0] count_en = 3'b111  // clz, ctz, cpop
) (
    input  logic                 rvfi_valid,
    input  bitmanip_pkg::insn_t  rvfi_insn,
    input  bitmanip_pkg::xlen_t  rvfi_rs1_rdata,
    output logic                 spec_valid,
    output bitmanip_pkg::xlen_t  spec_rd_wdata
);

    import bitmanip_pkg::*;

    logic       dec_clz;
    logic       dec_ctz;
    logic       dec_cpop;
    logic [5:0] clz_cnt;   // 0..32
    logic [5:0] ctz_cnt;
    logic [5:0] cpop_cnt;

    assign dec_clz  = rvfi_valid && ((rvfi_insn & clz_mask) == clz_match);
    assign dec_ctz  = rvfi_valid && ((rvfi_insn & ctz_mask) == ctz_match);
    assign dec_cpop = rvfi_valid && ((rvfi_insn & cpop_mask) == cpop_match);

    assign spec_valid = (dec_clz && count_en[0]) ||
                        (dec_ctz && count_en[1]) ||
                        (dec_cpop && count_en[2]);

    // highest set bit wins, scan upwards
    always_comb begin
        clz_cnt = 6'(xlen);  // zero operand
        for (int i = 0; i < xlen; i++) begin
            if (rvfi_rs1_rdata[i]) begin
                clz_cnt = 6'(xlen - 1 - i);
            end
        end
    end

    // lowest set bit wins, scan downwards
    always_comb begin
        ctz_cnt = 6'(xlen);
        for (int i = xlen - 1; i >= 0; i--) begin
            if (rvfi_rs1_rdata[i]) begin
                ctz_cnt = 6'(i);
            end
        end
    end

    always_comb begin
        cpop_cnt = '0;
        for (int i = 0; i < xlen; i++) begin
            cpop_cnt = cpop_cnt + 6'(rvfi_rs1_rdata[i]);
        end
    end

    assign spec_rd_wdata = ({xlen{dec_clz}} & xlen_t'(clz_cnt)) |
                           ({xlen{dec_ctz}} & xlen_t'(ctz_cnt)) |
                           ({xlen{dec_cpop}} & xlen_t'(cpop_cnt));

endmodule

// File: source/insn_rotate_checker.sv
module insn_rotate_checker #(
    parameter logic [2:0] rotate_en = 3'b111  // rol, ror, rori
) (
    input  logic                 rvfi_valid,
    input  bitmanip_pkg::insn_t  rvfi_insn,
    input  bitmanip_pkg::xlen_t  rvfi_rs1_rdata,
    input  bitmanip_pkg::xlen_t  rvfi_rs2_rdata,
    output logic                 spec_valid,
    output bitmanip_pkg::xlen_t  spec_rd_wdata
);

    import bitmanip_pkg::*;

    logic                dec_rol;
    logic                dec_ror;
    logic                dec_rori;
    logic [4:0]          rot_amt;
    logic [2*xlen-1:0]   rot_left;   // doubled operand, upper half is the result
    logic [2*xlen-1:0]   rot_right;  // doubled operand, lower half is the result

    assign dec_rol  = rvfi_valid && ((rvfi_insn & rol_mask) == rol_match);
    assign dec_ror  = rvfi_valid && ((rvfi_insn & ror_mask) == ror_match);
    assign dec_rori = rvfi_valid && ((rvfi_insn & rori_mask) == rori_match);

    assign spec_valid = (dec_rol && rotate_en[0]) ||
                        (dec_ror && rotate_en[1]) ||
                        (dec_rori && rotate_en[2]);

    // immediate shamt for rori, rs2 low bits otherwise
    assign rot_amt = dec_rori ? rvfi_insn[24:20] : rvfi_rs2_rdata[4:0];

    assign rot_left  = {rvfi_rs1_rdata, rvfi_rs1_rdata} << rot_amt;
    assign rot_right = {rvfi_rs1_rdata, rvfi_rs1_rdata} >> rot_amt;

    always_comb begin
        if (dec_rol) begin
            spec_rd_wdata = rot_left[2*xlen-1:xlen];
        end else if (dec_ror || dec_rori) begin
            spec_rd_wdata = rot_right[xlen-1:0];
        end else begin
            spec_rd_wdata = '0;
        end
    end

endmodule

// File: source/spec_arbiter.sv
module spec_arbiter (
    input  logic                                  rvfi_valid,
    input  logic [bitmanip_pkg::n_checkers-1:0]   claim_valid,
    input  bitmanip_pkg::xlen_t                   claim_wdata [bitmanip_pkg::n_checkers],
    output logic                                  sel_valid,
    output bitmanip_pkg::xlen_t                   sel_rd_wdata,
    output logic                                  unclaimed
);

    import bitmanip_pkg::*;

    assign sel_valid = |claim_valid;
    assign unclaimed = rvfi_valid && !(|claim_valid);  // nobody knows this insn

    // fixed priority, lowest index wins
    always_comb begin
        sel_rd_wdata = '0;
        for (int i = n_checkers - 1; i >= 0; i--) begin
            if (claim_valid[i]) begin
                sel_rd_wdata = claim_wdata[i];
            end
        end
    end

    // match patterns of the checkers must never overlap
    always_comb begin
        if (rvfi_valid) begin
            claims_onehot: assert ($onehot0(claim_valid))
                else $error("spec_arbiter: several checkers claim insn, claims %b",
                            claim_valid);
        end
    end

endmodule

// File: source/retire_comparator.sv
module retire_comparator (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sel_valid,
    input  bitmanip_pkg::xlen_t        sel_rd_wdata,
    input  logic                       unclaimed,
    input  bitmanip_pkg::insn_t        rvfi_insn,
    input  bitmanip_pkg::xlen_t        rvfi_pc_rdata,
    input  bitmanip_pkg::reg_addr_t    rvfi_rd_addr,
    input  bitmanip_pkg::xlen_t        rvfi_rd_wdata,
    input  bitmanip_pkg::xlen_t        rvfi_pc_wdata,
    output logic                       check_valid,
    output logic                       check_fail,
    output logic                       unknown_insn,
    output bitmanip_pkg::fail_count_t  fail_count
);

    import bitmanip_pkg::*;

    reg_addr_t exp_rd_addr;
    xlen_t     exp_rd_wdata;
    logic      s1_valid;
    logic      s1_unclaimed;
    reg_addr_t s1_exp_rd_addr;
    xlen_t     s1_exp_rd_wdata;
    xlen_t     s1_exp_pc_wdata;
    reg_addr_t s1_rd_addr;
    xlen_t     s1_rd_wdata;
    xlen_t     s1_pc_wdata;
    logic      mismatch;

    assign exp_rd_addr  = rvfi_insn[11:7];
    assign exp_rd_wdata = (exp_rd_addr == '0) ? '0 : sel_rd_wdata;  // x0 reads as zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s1_unclaimed <= 1'b0;
        end else begin
            s1_valid     <= sel_valid;
            s1_unclaimed <= unclaimed;
        end
    end

    always_ff @(posedge clk) begin
        s1_exp_rd_addr  <= exp_rd_addr;
        s1_exp_rd_wdata <= exp_rd_wdata;
        s1_exp_pc_wdata <= rvfi_pc_rdata + xlen_t'(4);  // no branches in zbb
        s1_rd_addr      <= rvfi_rd_addr;
        s1_rd_wdata     <= rvfi_rd_wdata;
        s1_pc_wdata     <= rvfi_pc_wdata;
    end

    assign mismatch = (s1_rd_addr != s1_exp_rd_addr) ||
                      (s1_rd_wdata != s1_exp_rd_wdata) ||
                      (s1_pc_wdata != s1_exp_pc_wdata);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            check_valid  <= 1'b0;
            check_fail   <= 1'b0;
            unknown_insn <= 1'b0;
            fail_count   <= '0;
        end else begin
            check_valid  <= s1_valid;
            check_fail   <= s1_valid && mismatch;
            unknown_insn <= s1_unclaimed;
            if (s1_valid && mismatch && (fail_count != '1)) begin
                fail_count <= fail_count + 1'b1;  // sticks at all ones
            end
        end
    end

    // each fail pulse is a checked retirement and is counted once
    fail_needs_check: assert property (@(posedge clk) disable iff (!rst_n)
        check_fail |-> check_valid &&
                       ((fail_count == '1) || (fail_count == $past(fail_count) + 1'b1)));

    // arbiter never raises both sel_valid and unclaimed
    check_or_unknown: assert property (@(posedge clk) disable iff (!rst_n)
        !(check_valid && unknown_insn));

endmodule

// File: source/bitmanip_spec_monitor.sv
module bitmanip_spec_monitor #(
    parameter logic [3:0] minmax_en = 4'b1111,
    parameter logic [2:0] logic_en  = 3'b111,
    parameter logic [2:0] count_en  = 3'b111,
    parameter logic [2:0] rotate_en = 3'b111
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rvfi_valid,
    input  bitmanip_pkg::insn_t        rvfi_insn,
    input  bitmanip_pkg::xlen_t        rvfi_pc_rdata,
    input  bitmanip_pkg::xlen_t        rvfi_rs1_rdata,
    input  bitmanip_pkg::xlen_t        rvfi_rs2_rdata,
    input  bitmanip_pkg::reg_addr_t    rvfi_rd_addr,
    input  bitmanip_pkg::xlen_t        rvfi_rd_wdata,
    input  bitmanip_pkg::xlen_t        rvfi_pc_wdata,
    output logic                       check_valid,
    output logic                       check_fail,
    output logic                       unknown_insn,
    output bitmanip_pkg::fail_count_t  fail_count
);

    import bitmanip_pkg::*;

    logic [n_checkers-1:0] claim_valid;              // one per checker
    xlen_t                 claim_wdata [n_checkers];
    logic                  sel_valid;
    xlen_t                 sel_rd_wdata;
    logic                  unclaimed;

    insn_minmax_checker #(.minmax_en(minmax_en)) u_minmax (
        .rvfi_valid     (rvfi_valid),
        .rvfi_insn      (rvfi_insn),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .rvfi_rs2_rdata (rvfi_rs2_rdata),
        .spec_valid     (claim_valid[0]),
        .spec_rd_wdata  (claim_wdata[0])
    );

    insn_logic_neg_checker #(.logic_en(logic_en)) u_logic_neg (
        .rvfi_valid     (rvfi_valid),
        .rvfi_insn      (rvfi_insn),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .rvfi_rs2_rdata (rvfi_rs2_rdata),
        .spec_valid     (claim_valid[1]),
        .spec_rd_wdata  (claim_wdata[1])
    );

    insn_count_checker #(.count_en(count_en)) u_count (
        .rvfi_valid     (rvfi_valid),
        .rvfi_insn      (rvfi_insn),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .spec_valid     (claim_valid[2]),
        .spec_rd_wdata  (claim_wdata[2])
    );

    insn_rotate_checker #(.rotate_en(rotate_en)) u_rotate (
        .rvfi_valid     (rvfi_valid),
        .rvfi_insn      (rvfi_insn),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .rvfi_rs2_rdata (rvfi_rs2_rdata),
        .spec_valid     (claim_valid[3]),
        .spec_rd_wdata  (claim_wdata[3])
    );

    spec_arbiter u_arbiter (
        .rvfi_valid   (rvfi_valid),
        .claim_valid  (claim_valid),
        .claim_wdata  (claim_wdata),
        .sel_valid    (sel_valid),
        .sel_rd_wdata (sel_rd_wdata),
        .unclaimed    (unclaimed)
    );

    retire_comparator u_comparator (
        .clk           (clk),
        .rst_n         (rst_n),
        .sel_valid     (sel_valid),
        .sel_rd_wdata  (sel_rd_wdata),
        .unclaimed     (unclaimed),
        .rvfi_insn     (rvfi_insn),
        .rvfi_pc_rdata (rvfi_pc_rdata),
        .rvfi_rd_addr  (rvfi_rd_addr),
        .rvfi_rd_wdata (rvfi_rd_wdata),
        .rvfi_pc_wdata (rvfi_pc_wdata),
        .check_valid   (check_valid),
        .check_fail    (check_fail),
        .unknown_insn  (unknown_insn),
        .fail_count    (fail_count)
    );

endmodule

// File: verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// instruction kinds used by the stimulus and the checks
localparam int k_max   = 0;
localparam int k_maxu  = 1;
localparam int k_min   = 2;
localparam int k_minu  = 3;
localparam int k_andn  = 4;
localparam int k_orn   = 5;
localparam int k_xnor  = 6;
localparam int k_clz   = 7;
localparam int k_ctz   = 8;
localparam int k_cpop  = 9;
localparam int k_rol   = 10;
localparam int k_ror   = 11;
localparam int k_rori  = 12;
localparam int k_other = 13;  // any non-zbb word
localparam int k_idle  = 14;
localparam int k_reset = 15;

// field2 is rs2, or shamt for rori
function automatic logic [31:0] encode_insn(input int kind, input logic [4:0] rs1,
                                            input logic [4:0] field2, input logic [4:0] rd);
    logic [16:0] fields;  // funct7, funct3, opcode
    logic [4:0]  f2;
    f2 = field2;
    case (kind)
        k_max:   fields = {7'b0000101, 3'b110, 7'b0110011};
        k_maxu:  fields = {7'b0000101, 3'b111, 7'b0110011};
        k_min:   fields = {7'b0000101, 3'b100, 7'b0110011};
        k_minu:  fields = {7'b0000101, 3'b101, 7'b0110011};
        k_andn:  fields = {7'b0100000, 3'b111, 7'b0110011};
        k_orn:   fields = {7'b0100000, 3'b110, 7'b0110011};
        k_xnor:  fields = {7'b0100000, 3'b100, 7'b0110011};
        k_rol:   fields = {7'b0110000, 3'b001, 7'b0110011};
        k_ror:   fields = {7'b0110000, 3'b101, 7'b0110011};
        k_rori:  fields = {7'b0110000, 3'b101, 7'b0010011};
        default: fields = {7'b0110000, 3'b001, 7'b0010011};  // clz, ctz, cpop
    endcase
    if (kind == k_clz || kind == k_ctz || kind == k_cpop) begin
        f2 = 5'(kind - k_clz);  // rs2 field picks the unary op
    end
    return {fields[16:10], f2, rs1, fields[9:7], rd, fields[6:0]};
endfunction

// keeps the random upper bits, replaces the opcode with a non-zbb one
function automatic logic [31:0] encode_other(input logic [31:0] raw, input int pick);
    logic [6:0] opcode;
    case (pick)
        0:       opcode = 7'b0110111;  // lui
        1:       opcode = 7'b0010111;  // auipc
        2:       opcode = 7'b1101111;  // jal
        default: opcode = 7'b1100011;  // branch
    endcase
    return {raw[31:7], opcode};
endfunction

function automatic logic [31:0] model_result(input int kind, input logic [31:0] a,
                                             input logic [31:0] b, input logic [4:0] amt);
    logic [31:0] r;
    int          n;
    r = '0;
    n = 0;
    case (kind)
        k_max:  r = ($signed(a) > $signed(b)) ? a : b;
        k_maxu: r = (a > b) ? a : b;
        k_min:  r = ($signed(a) < $signed(b)) ? a : b;
        k_minu: r = (a < b) ? a : b;
        k_andn: r = a & ~b;
        k_orn:  r = a | ~b;
        k_xnor: r = a ^ ~b;
        k_clz: begin
            for (int i = 31; i >= 0; i--) begin
                if (a[i]) break;
                n++;
            end
            r = 32'(n);  // 32 for a zero operand
        end
        k_ctz: begin
            for (int i = 0; i < 32; i++) begin
                if (a[i]) break;
                n++;
            end
            r = 32'(n);
        end
        k_cpop: r = 32'($countones(a));
        k_rol:  r = (a << amt) | (a >> (32 - int'(amt)));
        default: r = (a >> amt) | (a << (32 - int'(amt)));  // ror, rori
    endcase
    return r;
endfunction

function automatic string kind_name(input int kind);
    case (kind)
        k_max:   return "max";
        k_maxu:  return "maxu";
        k_min:   return "min";
        k_minu:  return "minu";
        k_andn:  return "andn";
        k_orn:   return "orn";
        k_xnor:  return "xnor";
        k_clz:   return "clz";
        k_ctz:   return "ctz";
        k_cpop:  return "cpop";
        k_rol:   return "rol";
        k_ror:   return "ror";
        k_rori:  return "rori";
        k_other: return "non_zbb";
        k_idle:  return "idle";
        default: return "reset";
    endcase
endfunction

`endif

// File: verif/tb_bitmanip_spec_monitor.sv
module tb_bitmanip_spec_monitor;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_model.svh"

    localparam int n_cycles       = 2000;
    localparam int timeout_cycles = n_cycles + 100;  // reset and drain need a handful

    typedef struct packed {
        logic        valid;
        logic        fail;
        logic        unknown;
        logic [15:0] count;
        logic [3:0]  kind;
        logic [1:0]  bad;  // corrupted field, 0 when clean
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        rvfi_valid;
    logic [31:0] rvfi_insn;
    logic [31:0] rvfi_pc_rdata;
    logic [31:0] rvfi_rs1_rdata;
    logic [31:0] rvfi_rs2_rdata;
    logic [4:0]  rvfi_rd_addr;
    logic [31:0] rvfi_rd_wdata;
    logic [31:0] rvfi_pc_wdata;
    logic        check_valid;
    logic        check_fail;
    logic        unknown_insn;
    logic [15:0] fail_count;

    expect_t     exp_q[$];           // one entry per driven cycle
    integer      seed        = 1;
    int          cycle_count = 0;
    logic [15:0] model_fails = '0;   // injected errors so far

    bitmanip_spec_monitor uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .rvfi_valid     (rvfi_valid),
        .rvfi_insn      (rvfi_insn),
        .rvfi_pc_rdata  (rvfi_pc_rdata),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .rvfi_rs2_rdata (rvfi_rs2_rdata),
        .rvfi_rd_addr   (rvfi_rd_addr),
        .rvfi_rd_wdata  (rvfi_rd_wdata),
        .rvfi_pc_wdata  (rvfi_pc_wdata),
        .check_valid    (check_valid),
        .check_fail     (check_fail),
        .unknown_insn   (unknown_insn),
        .fail_count     (fail_count)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure($sformatf("Timeout: run still going after %0d cycles",
                                        timeout_cycles));
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("Fail %s expected %0h actual %0h", test, expected, actual));
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // corner values now and then
    function automatic logic [31:0] rand_operand();
        int sel;
        sel = rand_below(8);
        case (sel)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            default: return $random(seed);
        endcase
    endfunction

    function automatic string test_name(input expect_t e, input string field);
        string base;
        base = kind_name(int'(e.kind));
        case (e.bad)
            2'd1:    base = {base, "_bad_rd_addr"};
            2'd2:    base = {base, "_bad_rd_wdata"};
            2'd3:    base = {base, "_bad_pc_wdata"};
            default: base = base;
        endcase
        return {base, ".", field};
    endfunction

    task automatic check_outputs(input expect_t e);
        valid_ok: assert (check_valid === e.valid)
            else report_mismatch(test_name(e, "check_valid"), 32'(e.valid), 32'(check_valid));
        fail_ok: assert (check_fail === e.fail)
            else report_mismatch(test_name(e, "check_fail"), 32'(e.fail), 32'(check_fail));
        unknown_ok: assert (unknown_insn === e.unknown)
            else report_mismatch(test_name(e, "unknown_insn"), 32'(e.unknown),
                                 32'(unknown_insn));
        count_ok: assert (fail_count === e.count)
            else report_mismatch(test_name(e, "fail_count"), 32'(e.count), 32'(fail_count));
    endtask

    // rvfi_valid low, a real zbb word on the bus to exercise the gating
    task automatic drive_idle();
        expect_t e;
        e = '0;
        rvfi_valid     = 1'b0;
        rvfi_insn      = encode_insn(rand_below(13), 5'(rand_below(32)), 5'(rand_below(32)),
                                     5'(rand_below(32)));
        rvfi_rs1_rdata = rand_operand();
        rvfi_rs2_rdata = rand_operand();
        e.count = model_fails;
        e.kind  = 4'(k_idle);
        exp_q.push_back(e);
    endtask

    task automatic drive_retirement();
        expect_t     e;
        int          kind;
        logic [4:0]  rs1_idx;
        logic [4:0]  rs2_idx;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] result;
        e       = '0;
        kind    = (rand_below(10) == 0) ? k_other : rand_below(13);
        rs1_idx = 5'(rand_below(32));
        rs2_idx = 5'(rand_below(32));
        rd      = (rand_below(8) == 0) ? 5'd0 : 5'(rand_below(32));  // extra x0 writes
        shamt   = 5'(rand_below(32));
        a       = rand_operand();
        b       = rand_operand();
        pc      = 32'($random(seed)) & 32'hffff_fffc;
        if (kind == k_other) begin
            rvfi_insn = encode_other($random(seed), rand_below(4));
        end else begin
            rvfi_insn = encode_insn(kind, rs1_idx, (kind == k_rori) ? shamt : rs2_idx, rd);
        end
        result = model_result(kind, a, b, (kind == k_rori) ? shamt : b[4:0]);
        if (rd == 5'd0) begin
            result = '0;  // x0 stays zero
        end
        rvfi_valid     = 1'b1;
        rvfi_pc_rdata  = pc;
        rvfi_rs1_rdata = a;
        rvfi_rs2_rdata = b;
        rvfi_rd_addr   = rvfi_insn[11:7];
        rvfi_rd_wdata  = result;
        rvfi_pc_wdata  = pc + 32'd4;
        e.kind = 4'(kind);
        if (kind == k_other) begin
            e.unknown = 1'b1;
        end else begin
            e.valid = 1'b1;
            if (rand_below(8) == 0) begin
                e.bad  = 2'(1 + rand_below(3));
                e.fail = 1'b1;
                case (e.bad)
                    2'd1:    rvfi_rd_addr  = rd ^ 5'(1 + rand_below(31));
                    2'd2:    rvfi_rd_wdata = result ^ (rand_operand() | 32'h1);
                    default: rvfi_pc_wdata = pc + 32'(4 * (2 + rand_below(4)));
                endcase
                if (model_fails != 16'hffff) begin
                    model_fails = model_fails + 16'd1;
                end
            end
        end
        e.count = model_fails;
        exp_q.push_back(e);
    endtask

    initial begin
        expect_t reset_exp;
        clk            = 1'b0;
        rst_n          = 1'b0;
        rvfi_valid     = 1'b0;
        rvfi_insn      = '0;
        rvfi_pc_rdata  = '0;
        rvfi_rs1_rdata = '0;
        rvfi_rs2_rdata = '0;
        rvfi_rd_addr   = '0;
        rvfi_rd_wdata  = '0;
        rvfi_pc_wdata  = '0;
        reset_exp      = '0;
        reset_exp.kind = 4'(k_reset);
        exp_q.push_back(reset_exp);  // two cycles of reset state before results arrive
        exp_q.push_back(reset_exp);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // a retirement driven now shows up two edges later
        for (int cyc = 0; cyc < n_cycles + 2; cyc++) begin
            if (exp_q.size() == 2) begin
                check_outputs(exp_q.pop_front());
            end
            if (cyc < n_cycles && rand_below(4) != 0) begin
                drive_retirement();
            end else begin
                drive_idle();
            end
            @(posedge clk);
            #1;
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+verif
source/bitmanip_pkg.sv
source/insn_minmax_checker.sv
source/insn_logic_neg_checker.sv
source/insn_count_checker.sv
source/insn_rotate_checker.sv
source/spec_arbiter.sv
source/retire_comparator.sv
source/bitmanip_spec_monitor.sv
verif/tb_bitmanip_spec_monitor.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_bitmanip_spec_monitor
FILELIST  = files.f
BUILD_DIR = obj_dir

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) verif/tb_model.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(BUILD_DIR)
